/* src/victim_pkg.sv */
`default_nettype none

package victim_pkg;

	// Cache geometry
	localparam int NUM_LINES = 4;   // Fully associative victim slots
	localparam int ADDR_W = 16;     // Line address, no offset bits
	localparam int LINE_W = 64;     // One whole cache line
	localparam int SLOT_W = $clog2(NUM_LINES);

	// Slot index into the victim arrays
	typedef logic [SLOT_W-1:0] slot_t;

	// Line address and line payload
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LINE_W-1:0] line_t;

	// Controller states
	// IDLE accepts a request and picks one of the paths below
	typedef enum logic [2:0] {
		IDLE         = 3'd0,    // Waiting for an L1 request
		SWAP         = 3'd1,    // Read hit, exchange with evicted line
		WRITE_L2     = 3'd2,    // Dirty LRU line going out to L2
		READ_L2      = 3'd3,    // Missed line coming in from L2
		WRITE_VICTIM = 3'd4     // Evicted line into a free or clean slot
	} vc_state_e;

endpackage

`default_nettype wire

/* src/victim_ctrl_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface victim_ctrl_if (
	input wire clk
);

	// Status from the datapath
	logic              hit;          // Read address found in a valid slot
	victim_pkg::slot_t hit_slot;
	logic              full;         // No invalid slot left
	logic              lru_dirty;    // Replacement candidate needs writeback

	// Strobes from the controller
	logic in_load;           // Capture L1 eviction
	logic out_load;          // Capture selected slot
	logic use_lru;           // Slot select, LRU instead of hit
	logic slot_load;         // Write input register into slot
	logic valid_in;
	logic lru_update;        // Selected slot becomes MRU
	logic l2_addr_from_req;  // L2 address is the read request
	logic out_from_l2;       // Output path takes L2 read data

	modport ctrl (
		input  clk,
		input  hit, hit_slot, full, lru_dirty,
		output in_load, out_load, use_lru, slot_load, valid_in,
		output lru_update, l2_addr_from_req, out_from_l2
	);

	modport dp (
		input  clk,
		output hit, hit_slot, full, lru_dirty,
		input  in_load, out_load, use_lru, slot_load, valid_in,
		input  lru_update, l2_addr_from_req, out_from_l2
	);

endinterface

`default_nettype wire

/* src/victim_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module victim_controller (
	input  wire       clk,
	input  wire       arst_n,
	input  wire       l1_read,
	input  wire       l1_write,
	input  wire       l2_resp,
	output logic      mem_resp,
	output logic      l2_read,
	output logic      l2_write,
	victim_ctrl_if.ctrl vc
);

	victim_pkg::vc_state_e state;
	victim_pkg::vc_state_e next_state;
	logic                  addr_sel_q;   // L2 address select, held for the whole read

	// State register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= victim_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	// Address select is registered from the next state so it is already
	// valid when l2_read rises and stays put through the response cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			addr_sel_q <= 1'b0;
		end else begin
			addr_sel_q <= (next_state == victim_pkg::READ_L2);
		end
	end

	assign vc.l2_addr_from_req = addr_sel_q;

	// Next state
	always_comb begin
		next_state = state;
		case (state)
			victim_pkg::IDLE: begin
				if (l1_read && vc.hit) begin
					next_state = victim_pkg::SWAP;
				end else if (l1_write) begin
					if (vc.full && vc.lru_dirty) begin
						next_state = victim_pkg::WRITE_L2;
					end else begin
						next_state = victim_pkg::WRITE_VICTIM;
					end
				end else if (l1_read) begin
					next_state = victim_pkg::READ_L2;   // Plain miss
				end
			end
			victim_pkg::SWAP: begin
				next_state = victim_pkg::IDLE;
			end
			victim_pkg::WRITE_VICTIM: begin
				next_state = l1_read ? victim_pkg::READ_L2 : victim_pkg::IDLE;
			end
			victim_pkg::WRITE_L2: begin
				if (l2_resp) begin
					next_state = l1_read ? victim_pkg::READ_L2 : victim_pkg::IDLE;
				end
			end
			victim_pkg::READ_L2: begin
				if (l2_resp) begin
					next_state = victim_pkg::IDLE;
				end
			end
			default: begin
				next_state = victim_pkg::IDLE;
			end
		endcase
	end

	// Outputs and datapath strobes
	always_comb begin
		mem_resp = 1'b0;
		l2_read = 1'b0;
		l2_write = 1'b0;
		vc.in_load = 1'b0;
		vc.out_load = 1'b0;
		vc.use_lru = 1'b0;
		vc.slot_load = 1'b0;
		vc.valid_in = 1'b0;
		vc.lru_update = 1'b0;
		vc.out_from_l2 = 1'b0;
		case (state)
			victim_pkg::IDLE: begin
				if (l1_read && vc.hit) begin
					vc.in_load = 1'b1;      // Evicted line, if any
					vc.out_load = 1'b1;     // Hit line toward L1
				end else if (l1_write) begin
					vc.in_load = 1'b1;
					vc.out_load = 1'b1;     // LRU line, for a possible writeback
					vc.use_lru = 1'b1;
				end
			end
			victim_pkg::SWAP: begin
				// Freed slot takes the eviction or becomes invalid
				vc.slot_load = 1'b1;
				vc.valid_in = l1_write;
				vc.lru_update = l1_write;
				mem_resp = 1'b1;
			end
			victim_pkg::WRITE_VICTIM: begin
				vc.use_lru = 1'b1;
				vc.slot_load = 1'b1;
				vc.valid_in = 1'b1;
				vc.lru_update = 1'b1;
				mem_resp = !l1_read;        // Read still to fetch from L2
			end
			victim_pkg::WRITE_L2: begin
				vc.use_lru = 1'b1;
				l2_write = 1'b1;
				if (l2_resp) begin
					vc.slot_load = 1'b1;    // Refill once the old line is safe
					vc.valid_in = 1'b1;
					vc.lru_update = 1'b1;
					mem_resp = !l1_read;
				end
			end
			victim_pkg::READ_L2: begin
				l2_read = 1'b1;
				vc.out_from_l2 = 1'b1;      // Forward L2 data straight to L1
				if (l2_resp) begin
					mem_resp = 1'b1;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/victim_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module victim_datapath (
	input  wire [victim_pkg::ADDR_W-1:0]  l1_addr,
	input  wire [victim_pkg::ADDR_W-1:0]  l1_evict_addr,
	input  wire [victim_pkg::LINE_W-1:0]  l1_evict_data,
	input  wire                           l1_evict_dirty,
	input  wire [victim_pkg::LINE_W-1:0]  l2_rdata,
	input  wire                           clk,
	input  wire                           arst_n,
	output logic [victim_pkg::LINE_W-1:0] l1_rdata,
	output logic [victim_pkg::ADDR_W-1:0] l2_addr,
	output logic [victim_pkg::LINE_W-1:0] l2_wdata,
	victim_ctrl_if.dp                     vc
);

	// Slot storage
	victim_pkg::addr_t                tags [victim_pkg::NUM_LINES];
	victim_pkg::line_t                lines [victim_pkg::NUM_LINES];
	logic [victim_pkg::NUM_LINES-1:0] valid;
	logic [victim_pkg::NUM_LINES-1:0] dirty;

	// Entry 0 is the oldest, the last entry the most recently used
	victim_pkg::slot_t order [victim_pkg::NUM_LINES];
	victim_pkg::slot_t order_next [victim_pkg::NUM_LINES];
	logic              order_shift;

	logic              hit_any;
	victim_pkg::slot_t hit_idx;
	victim_pkg::slot_t lru_slot;
	victim_pkg::slot_t sel_slot;

	// Input and output line registers
	victim_pkg::addr_t in_tag;
	victim_pkg::line_t in_data;
	logic              in_dirty;
	victim_pkg::addr_t out_tag;
	victim_pkg::line_t out_data;

	// Parallel tag compare
	always_comb begin
		hit_any = 1'b0;
		hit_idx = '0;
		for (int i = 0; i < victim_pkg::NUM_LINES; i++) begin
			if (valid[i] && tags[i] == l1_addr) begin
				hit_any = 1'b1;
				hit_idx = victim_pkg::slot_t'(i);
			end
		end
	end

	// Replacement choice, a free slot beats the oldest one
	always_comb begin
		lru_slot = order[0];
		for (int i = victim_pkg::NUM_LINES - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				lru_slot = victim_pkg::slot_t'(i);
			end
		end
	end

	assign sel_slot = vc.use_lru ? lru_slot : hit_idx;

	assign vc.hit = hit_any;
	assign vc.hit_slot = hit_idx;
	assign vc.full = &valid;
	assign vc.lru_dirty = valid[lru_slot] & dirty[lru_slot];

	// Move the selected slot to the young end
	always_comb begin
		order_next = order;
		order_shift = 1'b0;
		for (int i = 0; i < victim_pkg::NUM_LINES - 1; i++) begin
			if (order[i] == sel_slot) begin
				order_shift = 1'b1;
			end
			if (order_shift) begin
				order_next[i] = order[i + 1];
			end
		end
		order_next[victim_pkg::NUM_LINES - 1] = sel_slot;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < victim_pkg::NUM_LINES; i++) begin
				order[i] <= victim_pkg::slot_t'(i);
			end
		end else if (vc.lru_update) begin
			order <= order_next;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
			dirty <= '0;
		end else if (vc.slot_load) begin
			valid[sel_slot] <= vc.valid_in;
			dirty[sel_slot] <= in_dirty;
		end
	end

	always_ff @(posedge clk) begin
		if (vc.slot_load) begin
			tags[sel_slot] <= in_tag;
			lines[sel_slot] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (vc.in_load) begin
			in_tag <= l1_evict_addr;
			in_data <= l1_evict_data;
			in_dirty <= l1_evict_dirty;
		end
	end

	always_ff @(posedge clk) begin
		if (vc.out_load) begin
			out_tag <= tags[sel_slot];    // Writeback address
			out_data <= lines[sel_slot];
		end
	end

	assign l1_rdata = vc.out_from_l2 ? l2_rdata : out_data;   // Bypass on L2 response
	assign l2_wdata = out_data;
	assign l2_addr = vc.l2_addr_from_req ? l1_addr : out_tag;

endmodule

`default_nettype wire

/* src/victim_cache.sv */
`timescale 1ns/10ps
`default_nettype none

module victim_cache (
	input  wire                           clk,
	input  wire                           arst_n,

	// L1 side
	input  wire                           l1_read,
	input  wire                           l1_write,
	input  wire [victim_pkg::ADDR_W-1:0]  l1_addr,
	input  wire [victim_pkg::ADDR_W-1:0]  l1_evict_addr,
	input  wire [victim_pkg::LINE_W-1:0]  l1_evict_data,
	input  wire                           l1_evict_dirty,
	output logic                          mem_resp,
	output logic [victim_pkg::LINE_W-1:0] l1_rdata,

	// L2 side
	output logic                          l2_read,
	output logic                          l2_write,
	output logic [victim_pkg::ADDR_W-1:0] l2_addr,
	output logic [victim_pkg::LINE_W-1:0] l2_wdata,
	input  wire [victim_pkg::LINE_W-1:0]  l2_rdata,
	input  wire                           l2_resp
);

	victim_ctrl_if vc (
		.clk (clk)
	);

	victim_controller u_ctrl (
		.clk      (clk),
		.arst_n   (arst_n),
		.l1_read  (l1_read),
		.l1_write (l1_write),
		.l2_resp  (l2_resp),
		.mem_resp (mem_resp),
		.l2_read  (l2_read),
		.l2_write (l2_write),
		.vc       (vc.ctrl)
	);

	victim_datapath u_dp (
		.clk            (clk),
		.arst_n         (arst_n),
		.l1_addr        (l1_addr),
		.l1_evict_addr  (l1_evict_addr),
		.l1_evict_data  (l1_evict_data),
		.l1_evict_dirty (l1_evict_dirty),
		.l2_rdata       (l2_rdata),
		.l1_rdata       (l1_rdata),
		.l2_addr        (l2_addr),
		.l2_wdata       (l2_wdata),
		.vc             (vc.dp)
	);

endmodule

`default_nettype wire

/* sim/victim_cache_props.sv */
`timescale 1ns/10ps
`default_nettype none

module victim_cache_props (
	input wire                          clk,
	input wire                          arst_n,
	input wire                          l2_read,
	input wire                          l2_write,
	input wire                          l2_resp,
	input wire                          mem_resp,
	input wire [victim_pkg::ADDR_W-1:0] l2_addr,
	input wire [2:0]                    state
);

	a_l2_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(l2_read && l2_write))
		else $error("l2_read and l2_write high together");

	a_read_hold: assert property (@(posedge clk) disable iff (!arst_n)
		l2_read && !l2_resp |=> l2_read)
		else $error("l2_read dropped before l2_resp");

	a_write_hold: assert property (@(posedge clk) disable iff (!arst_n)
		l2_write && !l2_resp |=> l2_write)
		else $error("l2_write dropped before l2_resp");

	// Address must not move while L2 is still working
	a_addr_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(l2_read || l2_write) && !l2_resp |=> $stable(l2_addr))
		else $error("l2_addr changed before l2_resp");

	a_resp_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		mem_resp |=> !mem_resp)
		else $error("mem_resp longer than one cycle");

	// Every response closes the request
	a_resp_done: assert property (@(posedge clk) disable iff (!arst_n)
		mem_resp |=> state == victim_pkg::IDLE)
		else $error("controller not back in IDLE after mem_resp");

endmodule

bind victim_cache victim_cache_props props (
	.clk      (clk),
	.arst_n   (arst_n),
	.l2_read  (l2_read),
	.l2_write (l2_write),
	.l2_resp  (l2_resp),
	.mem_resp (mem_resp),
	.l2_addr  (l2_addr),
	.state    (u_ctrl.state)
);

`default_nettype wire

/* sim/victim_cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module victim_cache_tb;

	localparam int TIMEOUT = 64;    // Cycles allowed per wait
	localparam int NUM_RANDOM = 400;

	typedef struct packed {
		logic              rd_req;   // Request included a read
		logic              l2_rd;    // L2 read expected
		logic              wb;       // L2 writeback expected
		logic              fast;     // Response one cycle after acceptance
		victim_pkg::addr_t rd_addr;
		victim_pkg::addr_t wb_addr;
		victim_pkg::line_t wb_data;
		victim_pkg::line_t rdata;
	} expect_t;

	typedef struct packed {
		victim_pkg::addr_t tag;
		victim_pkg::line_t data;
		logic              dirty;
	} vline_t;

	typedef struct packed {
		logic              is_write;
		victim_pkg::addr_t addr;
		victim_pkg::line_t data;
	} l2_txn_t;

	logic                      clk;
	logic                      arst_n;
	logic                      l1_read;
	logic                      l1_write;
	victim_pkg::addr_t         l1_addr;
	victim_pkg::addr_t         l1_evict_addr;
	victim_pkg::line_t         l1_evict_data;
	logic                      l1_evict_dirty;
	logic                      mem_resp;
	victim_pkg::line_t         l1_rdata;
	logic                      l2_read;
	logic                      l2_write;
	victim_pkg::addr_t         l2_addr;
	victim_pkg::line_t         l2_wdata;
	victim_pkg::line_t         l2_rdata;
	logic                      l2_resp;

	victim_pkg::line_t l2_mem [0:65535];   // L2 contents as the DUT sees them
	victim_pkg::line_t golden [0:65535];   // L2 contents as the model expects
	vline_t            vq [$];             // Victim lines, front is LRU
	expect_t           exp_q [$];
	l2_txn_t           l2_log [$];
	logic [31:0]       rng;
	logic [31:0]       lat_rng;
	int                checks;
	int                errors;
	int                timeouts;
	logic              abort;

	victim_cache DUT (
		.clk            (clk),
		.arst_n         (arst_n),
		.l1_read        (l1_read),
		.l1_write       (l1_write),
		.l1_addr        (l1_addr),
		.l1_evict_addr  (l1_evict_addr),
		.l1_evict_data  (l1_evict_data),
		.l1_evict_dirty (l1_evict_dirty),
		.mem_resp       (mem_resp),
		.l1_rdata       (l1_rdata),
		.l2_read        (l2_read),
		.l2_write       (l2_write),
		.l2_addr        (l2_addr),
		.l2_wdata       (l2_wdata),
		.l2_rdata       (l2_rdata),
		.l2_resp        (l2_resp)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic victim_pkg::line_t fill_line(input victim_pkg::addr_t a);
		return {a, ~a, a ^ 16'h5ac3, a + 16'h7e11};
	endfunction

	function automatic victim_pkg::addr_t pool_addr(input logic [3:0] i);
		return 16'h3c00 | {8'h00, i, 4'h0};   // Small pool so that hits occur
	endfunction

	function automatic logic in_victim(input victim_pkg::addr_t a);
		foreach (vq[i]) begin
			if (vq[i].tag == a) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	function automatic victim_pkg::addr_t pick_evict(input logic [3:0] start,
			input victim_pkg::addr_t avoid);
		victim_pkg::addr_t a;
		a = pool_addr(start);
		for (int k = 0; k < 16; k++) begin
			a = pool_addr(4'(start + k));
			if (!in_victim(a) && a != avoid) begin
				return a;
			end
		end
		return a;
	endfunction

	// Reference model, updates the victim contents and golden L2 per request
	function automatic expect_t ref_predict(input logic r, input logic w,
			input victim_pkg::addr_t raddr, input victim_pkg::addr_t eaddr,
			input victim_pkg::line_t edata, input logic edirty);
		expect_t e;
		vline_t  nl;
		int      hit_i;
		e = '0;
		hit_i = -1;
		nl.tag = eaddr;
		nl.data = edata;
		nl.dirty = edirty;
		e.rd_req = r;
		e.rd_addr = raddr;
		if (r) begin
			foreach (vq[i]) begin
				if (vq[i].tag == raddr) begin
					hit_i = i;
				end
			end
		end
		if (hit_i >= 0) begin
			e.rdata = vq[hit_i].data;
			e.fast = 1'b1;
			vq.delete(hit_i);       // Line moves up to L1
			if (w) begin
				vq.push_back(nl);
			end
		end else begin
			if (w) begin
				if (vq.size() == victim_pkg::NUM_LINES) begin
					if (vq[0].dirty) begin
						e.wb = 1'b1;
						e.wb_addr = vq[0].tag;
						e.wb_data = vq[0].data;
						golden[vq[0].tag] = vq[0].data;
					end
					vq.delete(0);       // Clean LRU line is simply dropped
				end
				vq.push_back(nl);
				e.fast = !r && !e.wb;
			end
			if (r) begin
				e.l2_rd = 1'b1;
				e.rdata = golden[raddr];
			end
		end
		return e;
	endfunction

	task automatic check_equal(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name,
				expected, actual);
		end
	endtask

	task automatic send(input logic r, input logic w, input victim_pkg::addr_t raddr,
			input victim_pkg::addr_t eaddr, input victim_pkg::line_t edata,
			input logic edirty);
		expect_t e;
		int      n;
		if (!abort) begin
			e = ref_predict(r, w, raddr, eaddr, edata, edirty);
			exp_q.push_back(e);
			@(negedge clk);
			l1_read = r;
			l1_write = w;
			l1_addr = raddr;
			l1_evict_addr = eaddr;
			l1_evict_data = edata;
			l1_evict_dirty = edirty;
			n = 0;
			do begin
				@(posedge clk);
				n++;
			end while (!mem_resp && n < TIMEOUT);
			if (!mem_resp) begin
				timeouts++;
				abort = 1'b1;
				$display("Timeout: no mem_resp within %0d cycles at %0t", TIMEOUT, $time);
			end else if (e.fast) begin
				check_equal("mem_resp_latency", 2, n);   // Accept edge plus one cycle
			end
		end
	endtask

	task automatic idle_cycle;
		@(negedge clk);
		l1_read = 1'b0;
		l1_write = 1'b0;
	endtask

	task automatic evict_clean(input victim_pkg::addr_t a);
		send(1'b0, 1'b1, '0, a, golden[a], 1'b0);
	endtask

	task automatic evict_dirty(input victim_pkg::addr_t a);
		send(1'b0, 1'b1, '0, a, {a, ~a, 32'h1234_5678}, 1'b1);
	endtask

	// L2 memory with a random latency of 1 to 5 cycles
	always begin : l2_model
		int      lat;
		l2_txn_t t;
		@(negedge clk);
		l2_resp = 1'b0;
		if (arst_n && (l2_read || l2_write)) begin
			t.is_write = l2_write;
			t.addr = l2_addr;
			t.data = l2_wdata;
			l2_log.push_back(t);
			lat_rng = xorshift(lat_rng);
			lat = 1 + int'(lat_rng % 5);
			repeat (lat - 1) @(negedge clk);
			if (t.is_write) begin
				l2_mem[t.addr] = t.data;
			end else begin
				l2_rdata = l2_mem[t.addr];
			end
			l2_resp = 1'b1;
		end
	end

	// Compares each response and its L2 traffic with the prediction
	always @(posedge clk) begin : compare
		expect_t e;
		l2_txn_t t;
		int      n_wr;
		int      n_rd;
		if (arst_n && mem_resp) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("mem_resp pulsed at %0t with no request outstanding", $time);
			end else begin
				e = exp_q.pop_front();
				n_wr = 0;
				n_rd = 0;
				if (e.rd_req) begin
					check_equal("l1_rdata", e.rdata, l1_rdata);
				end
				while (l2_log.size() > 0) begin
					t = l2_log.pop_front();
					if (t.is_write) begin
						n_wr++;
						check_equal("l2_addr", e.wb_addr, t.addr);
						check_equal("l2_wdata", e.wb_data, t.data);
					end else begin
						n_rd++;
						check_equal("l2_addr", e.rd_addr, t.addr);
					end
				end
				check_equal("l2_write_count", e.wb, n_wr);
				check_equal("l2_read_count", e.l2_rd, n_rd);
			end
		end
	end

	initial begin
		logic              r;
		logic              w;
		logic              d;
		victim_pkg::addr_t ra;
		victim_pkg::addr_t ea;
		victim_pkg::line_t ed;
		int                n;
		clk = 1'b0;
		arst_n = 1'b0;
		l1_read = 1'b0;
		l1_write = 1'b0;
		l1_addr = '0;
		l1_evict_addr = '0;
		l1_evict_data = '0;
		l1_evict_dirty = 1'b0;
		l2_rdata = '0;
		l2_resp = 1'b0;
		rng = 32'hadf1dbbc;
		lat_rng = 32'hadf1dbbc ^ 32'h9e3779b9;   // Separate stream for L2 latency
		checks = 0;
		errors = 0;
		timeouts = 0;
		abort = 1'b0;
		for (int a = 0; a < 65536; a++) begin
			l2_mem[a] = fill_line(victim_pkg::addr_t'(a));
			golden[a] = fill_line(victim_pkg::addr_t'(a));
		end
		repeat (16) @(posedge clk);
		check_equal("mem_resp", 0, mem_resp);
		check_equal("l2_read", 0, l2_read);
		check_equal("l2_write", 0, l2_write);
		@(negedge clk);
		arst_n = 1'b1;

		send(1'b1, 1'b0, 16'h0010, '0, '0, 1'b0);   // Cold miss
		evict_dirty(16'h0100);
		send(1'b1, 1'b0, 16'h0100, '0, '0, 1'b0);   // Hit returns evicted data
		// Clean LRU, no writeback expected
		for (int i = 2; i < 6; i++) begin
			evict_clean(victim_pkg::addr_t'(i * 16'h0100));
		end
		evict_dirty(16'h0600);
		evict_dirty(16'h0700);
		evict_dirty(16'h0800);
		evict_dirty(16'h0900);
		evict_clean(16'h0a00);                      // Dirty LRU 0x0600 goes out
		send(1'b1, 1'b1, 16'h0700, 16'h0b00, golden[16'h0b00], 1'b0);   // Swap
		idle_cycle();
		send(1'b1, 1'b0, 16'h0700, '0, '0, 1'b0);   // Gone from victim, L2 read

		for (int i = 0; i < NUM_RANDOM; i++) begin
			rng = xorshift(rng);
			r = (rng[1:0] == 2'd0) || (rng[1:0] == 2'd2);
			w = (rng[1:0] == 2'd1) || (rng[1:0] == 2'd2);
			d = rng[8];
			ra = pool_addr(rng[7:4]);
			ea = pick_evict(rng[11:8], r ? ra : 16'hffff);
			rng = xorshift(rng);
			ed = d ? {rng, ~rng} : golden[ea];
			if (rng[1:0] == 2'd3 || (!r && !w)) begin
				idle_cycle();
			end else begin
				send(r, w, ra, ea, ed, d);
			end
		end
		idle_cycle();

		n = 0;
		while (exp_q.size() > 0 && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() > 0) begin
			timeouts++;
			$display("Responses still missing at the end of the run");
		end
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
src/victim_pkg.sv
src/victim_ctrl_if.sv
src/victim_controller.sv
src/victim_datapath.sv
src/victim_cache.sv
sim/victim_cache_props.sv
sim/victim_cache_tb.sv

/* Bender.yml */
package:
  name: victim_cache

sources:
  - src/victim_pkg.sv
  - src/victim_ctrl_if.sv
  - src/victim_controller.sv
  - src/victim_datapath.sv
  - src/victim_cache.sv
  - target: test
    files:
      - sim/victim_cache_props.sv
      - sim/victim_cache_tb.sv
